/* rtl/uart_macros.svh */
// widths, FIFO depth and register map for the UART; the FIFO depth must be a power of two
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

`define UART_DATA_W      8        // character width
`define AXI_DATA_W       32
`define AXI_ADDR_W       5        // eight word registers
`define AXI_RESP_W       2
`define UART_DIV_W       16       // bit period in clocks
`define UART_FIFO_DEPTH  8

// 115200 baud at 50 MHz
`define UART_DIV_INIT    16'd434

// word addresses, taken from address bits 4:2
`define UART_REG_RBR_THR 3'd0
`define UART_REG_IER     3'd1
`define UART_REG_LCR     3'd3
`define UART_REG_LSR     3'd5
`define UART_REG_DIV     3'd7

`define UART_LCR_STOP    2        // two stop bits
`define UART_LCR_PEN     3        // parity enable
`define UART_LCR_EPS     4        // even parity select
`define UART_LCR_DLAB    7        // divisor latch access

`define UART_LSR_DR      0
`define UART_LSR_PE      2
`define UART_LSR_THRE    5
`define UART_LSR_TEMT    6
`define UART_LSR_RESET   8'h60    // both tx flags set

`endif

/* rtl/uart_pkg.sv */
// shared UART types; character and divisor widths come from the macros header
`include "uart_macros.svh"

package uart_pkg;

  // one character on the line
  typedef logic [`UART_DATA_W-1:0] byte_t;

  // bit period in fixed_clk_i cycles
  typedef logic [`UART_DIV_W-1:0] div_t;

  // received character plus its parity result
  typedef struct packed {
    logic  perr;   // set when the parity bit was wrong
    byte_t data;
  } rx_entry_t;

  // frame format shared by both serial engines
  typedef struct packed {
    logic pen;     // parity bit present
    logic eps;     // even parity when set, odd otherwise
    logic stop;    // two stop bits when set
  } line_cfg_t;

endpackage

/* rtl/uart_fifo.sv */
// first-word-fall-through FIFO; DEPTH must be a power of two of at least 2, pushes while full are dropped
`timescale 1ns/1ps

module uart_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 8
) (
  input  logic     fixed_clk_i,
  input  logic     axi_aresetn_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pull_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;   // one extra bit to tell full from empty
  logic          do_push;
  logic          do_pull;

  if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
    $error("uart_fifo: DEPTH must be a power of two of at least 2");
  end

  assign do_push = push_i & ~full_o;
  assign do_pull = pull_i & ~empty_o;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (AW + 1)'(DEPTH));
  assign data_o  = mem[rd_ptr_q];   // head entry, no read latency

  always_ff @(posedge fixed_clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at DEPTH
      end
      if (do_pull) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pull})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither
      endcase
    end
  end

  // the consumer must look at empty_o before it pulls
  a_no_pull_when_empty: assert property (
    @(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    pull_i |-> !empty_o
  );

  a_count_in_range: assert property (
    @(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    count_q <= (AW + 1)'(DEPTH)
  );

endmodule

/* rtl/uart_tx.sv */
// UART serializer, 8N1 to 8P2; divisor must be at least 2 and should change only while idle
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
  input  logic                fixed_clk_i,
  input  logic                axi_aresetn_i,
  input  uart_pkg::div_t      div_i,
  input  uart_pkg::line_cfg_t cfg_i,
  input  logic                fifo_empty_i,
  input  uart_pkg::byte_t     fifo_data_i,
  output logic                fifo_pull_o,
  output logic                busy_o,
  output logic                uart_tx_o
);

  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  tx_state_e       state_q;
  uart_pkg::div_t  baud_cnt_q;
  logic [2:0]      bit_cnt_q;    // data bit index, stop bit index
  uart_pkg::byte_t shift_q;
  logic            parity_q;
  logic            tx_d;
  logic            tx_q;
  logic            bit_done;

  assign bit_done    = (baud_cnt_q == div_i - 1'b1);
  assign fifo_pull_o = (state_q == TX_IDLE) && !fifo_empty_i;   // take the byte as we leave idle
  assign busy_o      = (state_q != TX_IDLE);
  assign uart_tx_o   = tx_q;

  always_comb begin
    case (state_q)
      TX_START:  tx_d = 1'b0;
      TX_DATA:   tx_d = shift_q[0];   // lsb first
      TX_PARITY: tx_d = parity_q;
      default:   tx_d = 1'b1;         // idle and stop
    endcase
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q    <= TX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
    end else begin
      tx_q <= tx_d;   // registered line, whole frame shifted by one clock
      if (state_q == TX_IDLE) begin
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
        if (!fifo_empty_i) begin
          state_q <= TX_START;
        end
      end else if (!bit_done) begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end else begin
        baud_cnt_q <= '0;
        case (state_q)
          TX_START: state_q <= TX_DATA;
          TX_DATA: begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'(`UART_DATA_W - 1)) begin
              bit_cnt_q <= '0;
              state_q   <= cfg_i.pen ? TX_PARITY : TX_STOP;
            end
          end
          TX_PARITY: state_q <= TX_STOP;
          TX_STOP: begin
            if (cfg_i.stop && (bit_cnt_q == '0)) begin
              bit_cnt_q <= 3'd1;   // second stop bit
            end else begin
              state_q <= TX_IDLE;
            end
          end
          default: state_q <= TX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (fifo_pull_o) begin
      shift_q  <= fifo_data_i;
      parity_q <= cfg_i.eps ? ^fifo_data_i : ~^fifo_data_i;   // even when eps set
    end else if ((state_q == TX_DATA) && bit_done) begin
      shift_q <= shift_q >> 1;
    end
  end

  // the line rests at mark level between frames
  a_idle_line_high: assert property (
    @(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    (state_q == TX_IDLE) |-> uart_tx_o
  );

endmodule

/* rtl/uart_rx.sv */
// UART receiver with mid-bit sampling; only the first stop bit is checked and framing errors are not flagged
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
  input  logic                fixed_clk_i,
  input  logic                axi_aresetn_i,
  input  uart_pkg::div_t      div_i,
  input  uart_pkg::line_cfg_t cfg_i,
  input  logic                uart_rx_i,
  output logic                push_o,
  output uart_pkg::rx_entry_t entry_o
);

  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  rx_state_e           state_q;
  logic [2:0]          sync_q;      // two synchronizer flops plus one for the edge
  uart_pkg::div_t      baud_cnt_q;
  logic [2:0]          bit_cnt_q;
  uart_pkg::byte_t     shift_q;
  logic                perr_q;
  logic                push_q;
  uart_pkg::rx_entry_t entry_q;
  logic                rx_s;
  logic                fall;
  logic                mid_start;
  logic                bit_done;

  assign rx_s      = sync_q[1];
  assign fall      = sync_q[2] & ~sync_q[1];
  assign mid_start = (baud_cnt_q == (div_i >> 1));   // half a bit into the start bit
  assign bit_done  = (baud_cnt_q == div_i - 1'b1);   // a full bit later, mid of next bit
  assign push_o    = push_q;
  assign entry_o   = entry_q;

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      sync_q     <= '1;
      state_q    <= RX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      push_q     <= 1'b0;
    end else begin
      sync_q     <= {sync_q[1:0], uart_rx_i};
      push_q     <= 1'b0;
      baud_cnt_q <= baud_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          baud_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (fall) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (mid_start) begin
            baud_cnt_q <= '0;
            state_q    <= rx_s ? RX_IDLE : RX_DATA;   // high here means a glitch
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'(`UART_DATA_W - 1)) begin
              state_q <= cfg_i.pen ? RX_PARITY : RX_STOP;
            end
          end
        end
        RX_PARITY: begin
          if (bit_done) begin
            baud_cnt_q <= '0;
            state_q    <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            push_q  <= 1'b1;   // entry_q loads on the same edge
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if ((state_q == RX_DATA) && bit_done) begin
      shift_q <= {rx_s, shift_q[`UART_DATA_W-1:1]};   // lsb arrives first
    end
    if ((state_q == RX_PARITY) && bit_done) begin
      perr_q <= rx_s ^ (cfg_i.eps ? ^shift_q : ~^shift_q);
    end
    if ((state_q == RX_STOP) && bit_done) begin
      entry_q.data <= shift_q;
      entry_q.perr <= cfg_i.pen & perr_q;   // stale flag masked without parity
    end
  end

endmodule

/* rtl/uart_regs.sv */
// AXI4-Lite register block, one read and one write outstanding; wstrb is ignored and LCR word-length bits have no effect
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_regs (
  input  logic                      fixed_clk_i,
  input  logic                      axi_aresetn_i,
  input  logic [`AXI_ADDR_W-1:0]    axi_awaddr_i,
  input  logic                      axi_awvalid_i,
  output logic                      axi_awready_o,
  input  logic [`AXI_DATA_W-1:0]    axi_wdata_i,
  input  logic [`AXI_DATA_W/8-1:0]  axi_wstrb_i,
  input  logic                      axi_wvalid_i,
  output logic                      axi_wready_o,
  output logic [`AXI_RESP_W-1:0]    axi_bresp_o,
  output logic                      axi_bvalid_o,
  input  logic                      axi_bready_i,
  input  logic [`AXI_ADDR_W-1:0]    axi_araddr_i,
  input  logic                      axi_arvalid_i,
  output logic                      axi_arready_o,
  output logic [`AXI_DATA_W-1:0]    axi_rdata_o,
  output logic [`AXI_RESP_W-1:0]    axi_rresp_o,
  output logic                      axi_rvalid_o,
  input  logic                      axi_rready_i,
  output logic                      tx_push_o,
  output uart_pkg::byte_t           tx_data_o,
  input  logic                      tx_full_i,
  input  logic                      tx_empty_i,
  input  logic                      tx_busy_i,
  output logic                      rx_pull_o,
  input  uart_pkg::rx_entry_t       rx_entry_i,
  input  logic                      rx_empty_i,
  output uart_pkg::div_t            div_o,
  output uart_pkg::line_cfg_t       cfg_o,
  output logic                      read_interrupt_o
);

  typedef enum logic {W_IDLE, W_RESP} wr_state_e;
  typedef enum logic {R_IDLE, R_RESP} rd_state_e;

  wr_state_e              wr_state_q;
  rd_state_e              rd_state_q;
  logic [2:0]             waddr;
  logic [2:0]             raddr;
  logic                   wr_go;
  logic                   rd_go;
  logic                   thr_stall;
  logic                   dlab;
  logic [7:0]             lcr_q;
  logic [7:0]             lsr_q;
  logic                   ier_q;
  uart_pkg::div_t         div_new_q;   // written value, applied after the response
  uart_pkg::div_t         div_q;
  logic                   awready_q;
  logic                   wready_q;
  logic                   bvalid_q;
  logic                   arready_q;
  logic                   rvalid_q;
  logic                   tx_push_q;
  uart_pkg::byte_t        tx_data_q;
  logic [`AXI_DATA_W-1:0] rdata_d;
  logic [`AXI_DATA_W-1:0] rdata_q;
  logic                   irq_q;

  assign waddr     = axi_awaddr_i[`AXI_ADDR_W-1:2];
  assign raddr     = axi_araddr_i[`AXI_ADDR_W-1:2];
  assign dlab      = lcr_q[`UART_LCR_DLAB];
  assign thr_stall = (waddr == `UART_REG_RBR_THR) && !dlab && tx_full_i;   // wait for space
  assign wr_go     = (wr_state_q == W_IDLE) && axi_awvalid_i && axi_wvalid_i && !thr_stall;
  assign rd_go     = (rd_state_q == R_IDLE) && axi_arvalid_i;

  assign axi_awready_o    = awready_q;
  assign axi_wready_o     = wready_q;
  assign axi_bvalid_o     = bvalid_q;
  assign axi_bresp_o      = '0;   // always OKAY
  assign axi_arready_o    = arready_q;
  assign axi_rvalid_o     = rvalid_q;
  assign axi_rdata_o      = rdata_q;
  assign axi_rresp_o      = '0;
  assign tx_push_o        = tx_push_q;
  assign tx_data_o        = tx_data_q;
  assign div_o            = div_q;
  assign read_interrupt_o = irq_q;
  assign cfg_o = '{pen: lcr_q[`UART_LCR_PEN], eps: lcr_q[`UART_LCR_EPS],
                   stop: lcr_q[`UART_LCR_STOP]};

  // pop on the edge that accepts the RBR read
  assign rx_pull_o = rd_go && (raddr == `UART_REG_RBR_THR) && !dlab && !rx_empty_i;

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state_q <= W_IDLE;
      awready_q  <= 1'b0;
      wready_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      tx_push_q  <= 1'b0;
      lcr_q      <= '0;
      ier_q      <= 1'b0;
      div_new_q  <= `UART_DIV_INIT;
      div_q      <= `UART_DIV_INIT;
    end else begin
      awready_q <= 1'b0;   // ready strobes last one cycle
      wready_q  <= 1'b0;
      tx_push_q <= 1'b0;
      case (wr_state_q)
        W_IDLE: begin
          if (wr_go) begin
            awready_q  <= 1'b1;
            wready_q   <= 1'b1;
            bvalid_q   <= 1'b1;
            wr_state_q <= W_RESP;
            case (waddr)
              `UART_REG_RBR_THR: tx_push_q <= !dlab;   // dropped under DLAB
              `UART_REG_IER: begin
                if (!dlab) begin
                  ier_q <= axi_wdata_i[0];
                end
              end
              `UART_REG_LCR: lcr_q <= axi_wdata_i[7:0];
              `UART_REG_DIV: begin
                if (dlab) begin
                  div_new_q <= axi_wdata_i[`UART_DIV_W-1:0];
                end
              end
              default: ;   // unmapped, response only
            endcase
          end
        end
        W_RESP: begin
          if (axi_bready_i) begin
            bvalid_q   <= 1'b0;
            div_q      <= div_new_q;
            wr_state_q <= W_IDLE;
          end
        end
        default: wr_state_q <= W_IDLE;
      endcase
    end
  end

  always_comb begin
    rdata_d = '0;
    case (raddr)
      `UART_REG_RBR_THR: rdata_d[7:0] = (dlab || rx_empty_i) ? 8'h00 : rx_entry_i.data;
      `UART_REG_IER:     rdata_d[0]   = ier_q & !dlab;
      `UART_REG_LCR:     rdata_d[7:0] = lcr_q;
      `UART_REG_LSR:     rdata_d[7:0] = lsr_q;
      `UART_REG_DIV:     rdata_d[`UART_DIV_W-1:0] = dlab ? div_q : '0;
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state_q <= R_IDLE;
      arready_q  <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      arready_q <= 1'b0;
      case (rd_state_q)
        R_IDLE: begin
          if (rd_go) begin
            arready_q  <= 1'b1;
            rvalid_q   <= 1'b1;
            rd_state_q <= R_RESP;
          end
        end
        R_RESP: begin
          if (axi_rready_i) begin
            rvalid_q   <= 1'b0;
            rd_state_q <= R_IDLE;
          end
        end
        default: rd_state_q <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (wr_go) begin
      tx_data_q <= axi_wdata_i[`UART_DATA_W-1:0];
    end
    if (rd_go) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      lsr_q <= `UART_LSR_RESET;
      irq_q <= 1'b0;
    end else begin
      lsr_q                 <= '0;
      lsr_q[`UART_LSR_DR]   <= !rx_empty_i;
      lsr_q[`UART_LSR_PE]   <= !rx_empty_i && rx_entry_i.perr;   // flag of the head entry
      lsr_q[`UART_LSR_THRE] <= !tx_full_i;
      lsr_q[`UART_LSR_TEMT] <= tx_empty_i && !tx_busy_i;
      irq_q                 <= !rx_empty_i && ier_q;
    end
  end

  // a response stays offered until the master takes it
  a_bvalid_held: assert property (
    @(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    (axi_bvalid_o && !axi_bready_i) |=> axi_bvalid_o
  );

  a_rvalid_held: assert property (
    @(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    (axi_rvalid_o && !axi_rready_i) |=> (axi_rvalid_o && $stable(axi_rdata_o))
  );

endmodule

/* rtl/axi_uart_top.sv */
// AXI4-Lite UART top level; every port, AXI included, is sampled on fixed_clk_i
`timescale 1ns/1ps
`include "uart_macros.svh"

module axi_uart_top (
  input  logic                      fixed_clk_i,
  input  logic                      axi_aresetn_i,
  input  logic [`AXI_ADDR_W-1:0]    axi_awaddr_i,
  input  logic                      axi_awvalid_i,
  output logic                      axi_awready_o,
  input  logic [`AXI_DATA_W-1:0]    axi_wdata_i,
  input  logic [`AXI_DATA_W/8-1:0]  axi_wstrb_i,
  input  logic                      axi_wvalid_i,
  output logic                      axi_wready_o,
  output logic [`AXI_RESP_W-1:0]    axi_bresp_o,
  output logic                      axi_bvalid_o,
  input  logic                      axi_bready_i,
  input  logic [`AXI_ADDR_W-1:0]    axi_araddr_i,
  input  logic                      axi_arvalid_i,
  output logic                      axi_arready_o,
  output logic [`AXI_DATA_W-1:0]    axi_rdata_o,
  output logic [`AXI_RESP_W-1:0]    axi_rresp_o,
  output logic                      axi_rvalid_o,
  input  logic                      axi_rready_i,
  input  logic                      uart_rx_i,
  output logic                      uart_tx_o,
  output logic                      read_interrupt_o
);

  logic                tx_push;
  uart_pkg::byte_t     tx_wdata;    // regs to tx FIFO
  uart_pkg::byte_t     tx_rdata;    // tx FIFO to serializer
  logic                tx_pull;
  logic                tx_full;
  logic                tx_empty;
  logic                tx_busy;
  logic                rx_push;
  uart_pkg::rx_entry_t rx_wentry;   // receiver to rx FIFO
  uart_pkg::rx_entry_t rx_rentry;   // rx FIFO head to regs
  logic                rx_pull;
  logic                rx_empty;
  uart_pkg::div_t      div;
  uart_pkg::line_cfg_t cfg;

  uart_regs u_regs (
    .fixed_clk_i, .axi_aresetn_i,
    .axi_awaddr_i, .axi_awvalid_i, .axi_awready_o,
    .axi_wdata_i, .axi_wstrb_i, .axi_wvalid_i, .axi_wready_o,
    .axi_bresp_o, .axi_bvalid_o, .axi_bready_i,
    .axi_araddr_i, .axi_arvalid_i, .axi_arready_o,
    .axi_rdata_o, .axi_rresp_o, .axi_rvalid_o, .axi_rready_i,
    .tx_push_o (tx_push), .tx_data_o (tx_wdata), .tx_full_i (tx_full),
    .tx_empty_i (tx_empty), .tx_busy_i (tx_busy),
    .rx_pull_o (rx_pull), .rx_entry_i (rx_rentry), .rx_empty_i (rx_empty),
    .div_o (div), .cfg_o (cfg), .read_interrupt_o
  );

  uart_fifo #(.payload_t(uart_pkg::byte_t), .DEPTH(`UART_FIFO_DEPTH)) u_tx_fifo (
    .fixed_clk_i, .axi_aresetn_i,
    .push_i (tx_push), .data_i (tx_wdata), .pull_i (tx_pull),
    .data_o (tx_rdata), .empty_o (tx_empty), .full_o (tx_full)
  );

  // full rx pushes drop inside the FIFO
  uart_fifo #(.payload_t(uart_pkg::rx_entry_t), .DEPTH(`UART_FIFO_DEPTH)) u_rx_fifo (
    .fixed_clk_i, .axi_aresetn_i,
    .push_i (rx_push), .data_i (rx_wentry), .pull_i (rx_pull),
    .data_o (rx_rentry), .empty_o (rx_empty), .full_o ()
  );

  uart_tx u_tx (
    .fixed_clk_i, .axi_aresetn_i, .div_i (div), .cfg_i (cfg),
    .fifo_empty_i (tx_empty), .fifo_data_i (tx_rdata), .fifo_pull_o (tx_pull),
    .busy_o (tx_busy), .uart_tx_o
  );

  uart_rx u_rx (
    .fixed_clk_i, .axi_aresetn_i, .div_i (div), .cfg_i (cfg),
    .uart_rx_i, .push_o (rx_push), .entry_o (rx_wentry)
  );

endmodule

/* tb/tb_axi_uart.sv */
// loopback and frame-driver testbench for the AXI4-Lite UART; assumes a 10 ns clock and divisors of 6 to 16
`timescale 1ns/1ps
`include "uart_macros.svh"

module tb_axi_uart;

  localparam int NROWS    = 5;
  localparam int POLL_MAX = 4000;   // cycles or LSR polls before giving up

  localparam logic [`AXI_ADDR_W-1:0] A_RBR = {`UART_REG_RBR_THR, 2'b00};
  localparam logic [`AXI_ADDR_W-1:0] A_IER = {`UART_REG_IER, 2'b00};
  localparam logic [`AXI_ADDR_W-1:0] A_LCR = {`UART_REG_LCR, 2'b00};
  localparam logic [`AXI_ADDR_W-1:0] A_LSR = {`UART_REG_LSR, 2'b00};
  localparam logic [`AXI_ADDR_W-1:0] A_DIV = {`UART_REG_DIV, 2'b00};

  // LCR with DLAB clear, divisor, bytes sent, expected bits per frame
  logic [7:0] row_lcr  [NROWS] = '{8'h03, 8'h0b, 8'h1b, 8'h07, 8'h1f};
  int         row_div  [NROWS] = '{16, 6, 10, 7, 12};
  int         row_cnt  [NROWS] = '{4, 16, 9, 12, 16};
  int         row_bits [NROWS] = '{10, 11, 11, 11, 12};

  logic                     fixed_clk = 1'b0;
  logic                     axi_aresetn;
  logic [`AXI_ADDR_W-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`AXI_DATA_W-1:0]   wdata;
  logic [`AXI_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [`AXI_RESP_W-1:0]   bresp;
  logic                     bvalid;
  logic                     bready;
  logic [`AXI_ADDR_W-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [`AXI_DATA_W-1:0]   rdata;
  logic [`AXI_RESP_W-1:0]   rresp;
  logic                     rvalid;
  logic                     rready;
  logic                     uart_rx;
  logic                     uart_tx;
  logic                     irq;
  logic                     loopback;    // rx line fed from tx when set
  logic                     drv_line;    // local frame driver
  logic [31:0]              rng_state = 32'h06fd5bd0;
  int                       cur_div;
  logic [7:0]               cur_lcr;
  logic [7:0]               tx_exp [$];  // bytes still due on uart_tx_o
  logic [7:0]               rx_exp [$];  // bytes still due from RBR

  assign uart_rx = loopback ? uart_tx : drv_line;

  always #5 fixed_clk = ~fixed_clk;

  axi_uart_top DUT (
    .fixed_clk_i      (fixed_clk),
    .axi_aresetn_i    (axi_aresetn),
    .axi_awaddr_i     (awaddr),
    .axi_awvalid_i    (awvalid),
    .axi_awready_o    (awready),
    .axi_wdata_i      (wdata),
    .axi_wstrb_i      (wstrb),
    .axi_wvalid_i     (wvalid),
    .axi_wready_o     (wready),
    .axi_bresp_o      (bresp),
    .axi_bvalid_o     (bvalid),
    .axi_bready_i     (bready),
    .axi_araddr_i     (araddr),
    .axi_arvalid_i    (arvalid),
    .axi_arready_o    (arready),
    .axi_rdata_o      (rdata),
    .axi_rresp_o      (rresp),
    .axi_rvalid_o     (rvalid),
    .axi_rready_i     (rready),
    .uart_rx_i        (uart_rx),
    .uart_tx_o        (uart_tx),
    .read_interrupt_o (irq)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int frame_len(input logic [7:0] lcr);
    return 10 + int'(lcr[`UART_LCR_PEN]) + int'(lcr[`UART_LCR_STOP]);
  endfunction

  // line level of bit k: start, 8 data lsb first, parity, stop
  function automatic logic frame_bit(input int k, input logic [7:0] b, input logic [7:0] lcr);
    int   ones;
    int   i;
    logic par;
    ones = 0;
    for (i = 0; i < 8; i++) begin
      ones += int'(b[i]);
    end
    par = ((ones % 2) == 1) == lcr[`UART_LCR_EPS];   // total ones even with EPS, odd without
    if (k == 0) begin
      return 1'b0;
    end else if (k <= 8) begin
      return b[k-1];
    end else if ((k == 9) && lcr[`UART_LCR_PEN]) begin
      return par;
    end else begin
      return 1'b1;
    end
  endfunction

  task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic write_reg(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                           output int waited);
    waited  = 0;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!awready && (waited <= POLL_MAX)) begin
      @(posedge fixed_clk);
      #1;
      waited++;
    end
    if (!awready) begin
      abort_run("write address was never accepted");
    end else begin
      compare_val("axi_wready_o", wready, 1);
      compare_val("axi_bvalid_o", bvalid, 1);
      compare_val("axi_bresp_o", bresp, 0);   // OKAY
      @(posedge fixed_clk);                   // handshake edge
      #1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
    end
  endtask

  task automatic read_reg(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data);
    int waited;
    waited  = 0;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready && (waited <= POLL_MAX)) begin
      @(posedge fixed_clk);
      #1;
      waited++;
    end
    if (!arready) begin
      abort_run("read address was never accepted");
    end else begin
      compare_val("axi_rvalid_o", rvalid, 1);
      compare_val("axi_rresp_o", rresp, 0);
      data = rdata;
      @(posedge fixed_clk);
      #1;
      arvalid = 1'b0;
      rready  = 1'b0;
    end
  endtask

  // poll LSR until the given bit is set
  task automatic poll_lsr(input int bit_pos, input string what, output logic [31:0] lsr);
    int polls;
    polls = 0;
    lsr   = '0;
    while (!lsr[bit_pos] && (polls < POLL_MAX)) begin
      read_reg(A_LSR, lsr);
      polls++;
    end
    if (!lsr[bit_pos]) begin
      abort_run({"LSR never showed ", what});
    end
  endtask

  task automatic set_line(input logic [7:0] lcr, input int div);
    int w;
    write_reg(A_LCR, 32'h80, w);   // DLAB on
    write_reg(A_DIV, div, w);
    write_reg(A_LCR, lcr, w);
    cur_div = div;
    cur_lcr = lcr;
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_par);
    int k;
    for (k = 0; k < frame_len(cur_lcr); k++) begin
      drv_line = frame_bit(k, b, cur_lcr) ^ (bad_par && (k == 9));
      repeat (cur_div) @(posedge fixed_clk);
      #1;
    end
  endtask

  task automatic run_row(input int r);
    int          max_wait;
    logic [31:0] lsr;
    set_line(row_lcr[r], row_div[r]);
    max_wait = 0;
    fork
      begin : writer
        int         n;
        int         w;
        logic [7:0] b;
        for (n = 0; n < row_cnt[r]; n++) begin
          rng_state = xorshift32(rng_state);
          b         = rng_state[7:0];
          tx_exp.push_back(b);
          rx_exp.push_back(b);
          write_reg(A_RBR, b, w);
          if (w > max_wait) begin
            max_wait = w;
          end
        end
      end
      begin : reader
        int          m;
        logic [31:0] d;
        logic [31:0] st;
        for (m = 0; m < row_cnt[r]; m++) begin
          poll_lsr(`UART_LSR_DR, "data ready", st);
          read_reg(A_RBR, d);
          compare_val("rbr_data", d[7:0], rx_exp.pop_front());
        end
      end
    join
    if (row_cnt[r] > `UART_FIFO_DEPTH + 1) begin
      compare_val("awready_delayed", max_wait > 2, 1);   // THR back-pressure seen
    end
    poll_lsr(`UART_LSR_TEMT, "transmitter empty", lsr);
    compare_val("frames_pending", tx_exp.size(), 0);
  endtask

  task automatic check_parity_error;
    logic [31:0] d;
    set_line(8'h18, 8);   // even parity, one stop bit
    send_frame(8'hc3, 1'b1);
    poll_lsr(`UART_LSR_DR, "data ready", d);
    compare_val("lsr_pe", d[`UART_LSR_PE], 1);
    read_reg(A_RBR, d);
    compare_val("rbr_data", d[7:0], 8'hc3);
    send_frame(8'h3c, 1'b0);
    poll_lsr(`UART_LSR_DR, "data ready", d);
    compare_val("lsr_pe", d[`UART_LSR_PE], 0);
    read_reg(A_RBR, d);
    compare_val("rbr_data", d[7:0], 8'h3c);
  endtask

  task automatic check_interrupt;
    logic [31:0] d;
    int          w;
    int          n;
    write_reg(A_IER, 1, w);
    compare_val("read_interrupt_o", irq, 0);
    send_frame(8'h5a, 1'b0);
    n = 0;
    while ((irq !== 1'b1) && (n < POLL_MAX)) begin
      @(posedge fixed_clk);
      #1;
      n++;
    end
    compare_val("read_interrupt_o", irq, 1);
    read_reg(A_RBR, d);
    compare_val("rbr_data", d[7:0], 8'h5a);
    repeat (3) @(posedge fixed_clk);   // pop, then registered flag
    #1;
    compare_val("read_interrupt_o", irq, 0);
    write_reg(A_IER, 0, w);
    send_frame(8'ha5, 1'b0);
    poll_lsr(`UART_LSR_DR, "data ready", d);
    compare_val("read_interrupt_o", irq, 0);
    read_reg(A_RBR, d);
    compare_val("rbr_data", d[7:0], 8'ha5);
  endtask

  task automatic check_dlab_gating;
    logic [31:0] d;
    logic [7:0]  b;
    int          w;
    loopback = 1'b1;
    write_reg(A_LCR, 32'h80 | cur_lcr, w);
    write_reg(A_RBR, 8'h77, w);   // must not reach the tx FIFO
    repeat (2 * 12 * cur_div) begin
      @(negedge fixed_clk);
      compare_val("uart_tx_o", uart_tx, 1);
    end
    @(posedge fixed_clk);
    #1;
    write_reg(A_LCR, cur_lcr, w);
    write_reg(A_DIV, 3, w);       // ignored, monitor keeps the old period
    rng_state = xorshift32(rng_state);
    b         = rng_state[7:0];
    tx_exp.push_back(b);
    write_reg(A_RBR, b, w);
    poll_lsr(`UART_LSR_DR, "data ready", d);
    read_reg(A_RBR, d);
    compare_val("rbr_data", d[7:0], b);
    poll_lsr(`UART_LSR_TEMT, "transmitter empty", d);
  endtask

  // decodes uart_tx_o with the configured divisor, window trimmed by one cycle each side
  initial begin : line_monitor
    int         k;
    int         j;
    int         div;
    logic [7:0] lcr;
    logic [7:0] b;
    wait (axi_aresetn === 1'b1);
    forever begin
      @(negedge fixed_clk);
      if (!uart_tx) begin
        if (tx_exp.size() == 0) begin
          abort_run("frame on uart_tx_o without a pending THR byte");
        end else begin
          b   = tx_exp.pop_front();
          div = cur_div;
          lcr = cur_lcr;
          for (k = 0; k < frame_len(lcr); k++) begin
            for (j = 0; j < div; j++) begin
              if ((k != 0) || (j != 0)) begin
                @(negedge fixed_clk);
              end
              if ((j >= 1) && (j <= div - 2)) begin
                compare_val("uart_tx_o", uart_tx, frame_bit(k, b, lcr));
              end
            end
          end
        end
      end
    end
  end

  initial begin : watchdog
    longint limit_ns;
    int     r;
    limit_ns = 10000;   // 10 us margin
    for (r = 0; r < NROWS; r++) begin
      limit_ns += 2 * row_cnt[r] * row_bits[r] * row_div[r] * 10;
    end
    #(limit_ns);
    $display("ERROR: timeout after %0d ns, the run did not finish", limit_ns);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    logic [31:0] d;
    int          r;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '1;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    loopback    = 1'b0;
    drv_line    = 1'b1;
    axi_aresetn = 1'b0;
    cur_div     = `UART_DIV_INIT;
    cur_lcr     = 8'h00;
    repeat (8) @(posedge fixed_clk);
    #1;
    axi_aresetn = 1'b1;

    compare_val("axi_awready_o", awready, 0);
    compare_val("axi_wready_o", wready, 0);
    compare_val("axi_bvalid_o", bvalid, 0);
    compare_val("axi_arready_o", arready, 0);
    compare_val("axi_rvalid_o", rvalid, 0);
    compare_val("uart_tx_o", uart_tx, 1);
    compare_val("read_interrupt_o", irq, 0);
    read_reg(A_LSR, d);
    compare_val("lsr", d, 32'h60);
    read_reg(A_RBR, d);
    compare_val("rbr_empty", d[7:0], 0);

    loopback = 1'b1;
    for (r = 0; r < NROWS; r++) begin
      run_row(r);
    end

    loopback = 1'b0;
    check_parity_error();
    check_interrupt();
    check_dlab_gating();
    compare_val("frames_pending", tx_exp.size(), 0);

    $display("all tests passed");
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/axi_uart_top.sv
tb/tb_axi_uart.sv

/* Bender.yml */
package:
  name: axi_uart

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_pkg.sv
      - rtl/uart_fifo.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_regs.sv
      - rtl/axi_uart_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_axi_uart.sv
